// ==== include/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// width of every CSR and of the access data path
`define CSR_DATA_W 32

// CSR number field of csrrd / csrwr / csrxchg
`define CSR_NUM_W 14

// exception codes that also update BADV
// ADEF records the fetch pc
`define CSR_ECODE_ADE 6'h08

// ALE records the data vaddr
`define CSR_ECODE_ALE 6'h09

// timer counter value meaning "stopped"
// reset value of TVAL and the state a one-shot timer falls back to
`define CSR_TIMER_IDLE 32'hffff_ffff

`endif

// ==== source/csr_pkg.sv ====
`include "csr_defs.svh"

package csr_pkg;

    // implemented CSR numbers
    // anything else is unimplemented: writes are dropped, reads give zero
    typedef enum logic [`CSR_NUM_W-1:0] {
        csr_crmd   = 14'h000,
        csr_prmd   = 14'h001,
        csr_ecfg   = 14'h004,
        csr_estat  = 14'h005,
        csr_era    = 14'h006,
        csr_badv   = 14'h007,
        csr_eentry = 14'h00c,
        csr_save0  = 14'h030,
        csr_save1  = 14'h031,
        csr_save2  = 14'h032,
        csr_save3  = 14'h033,
        csr_tid    = 14'h040,
        csr_tcfg   = 14'h041,
        csr_tval   = 14'h042,
        csr_ticlr  = 14'h044,
        csr_llbctl = 14'h060
    } csr_num_e;

    // one CSR access from the pipeline, issued every cycle
    // num stays a plain vector so unimplemented numbers can be carried
    typedef struct packed {
        logic                   re;
        logic                   we;
        logic [`CSR_NUM_W-1:0]  num;
        logic [`CSR_DATA_W-1:0] wmask;
        logic [`CSR_DATA_W-1:0] wvalue;
    } csr_access_t;

    // exception reported at writeback
    typedef struct packed {
        logic                   valid;
        logic [5:0]             ecode;
        logic [8:0]             esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] vaddr;
    } wb_exc_t;

    // TCFG layout, en in bit 0
    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    // interrupt lines in ESTAT.IS / ECFG.LIE bit order
    // bit 0 is sw[0], bit 12 is the IPI line
    typedef struct packed {
        logic       ipi;
        logic       timer;
        logic       rsvd;
        logic [7:0] hw;
        logic [1:0] sw;
    } int_lines_t;

endpackage

// ==== source/csr_regfile.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_regfile import csr_pkg::*; #(
    parameter logic [`CSR_DATA_W-1:0] core_id = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_access_t            csr_acc,
    input  wb_exc_t                wb_exc,
    input  logic                   ertn_flush,
    input  logic [7:0]             hw_int,
    input  logic                   timer_fire,
    input  logic [`CSR_DATA_W-1:0] tval,
    output logic [`CSR_DATA_W-1:0] csr_rvalue,
    output tcfg_t                  tcfg,
    output logic                   tcfg_load,
    output int_lines_t             estat_is,
    output int_lines_t             ecfg_lie,
    output logic                   crmd_ie,
    output logic [`CSR_DATA_W-1:0] eentry,
    output logic [`CSR_DATA_W-1:0] era
);

    // LIE bit 10 has no line behind it
    localparam logic [12:0] lie_mask = 13'h1bff;

    csr_num_e               num;
    logic                   wen;
    logic [1:0]             crmd_plv;
    logic [1:0]             prmd_pplv;
    logic                   prmd_pie;
    logic [5:0]             estat_ecode;
    logic [8:0]             estat_esubcode;
    logic [`CSR_DATA_W-1:0] badv;
    logic [25:0]            eentry_va;
    logic [`CSR_DATA_W-1:0] save_q [4];
    logic                   llbctl_klo;
    logic [`CSR_DATA_W-1:0] tid;
    tcfg_t                  tcfg_q;
    tcfg_t                  tcfg_next;
    logic                   tcfg_wr;
    logic                   ticlr_clr;
    logic                   exc_addr;
    logic [`CSR_DATA_W-1:0] crmd_rd;
    logic [`CSR_DATA_W-1:0] prmd_rd;
    logic [`CSR_DATA_W-1:0] ecfg_rd;
    logic [`CSR_DATA_W-1:0] estat_rd;
    logic [`CSR_DATA_W-1:0] llbctl_rd;
    logic [`CSR_DATA_W-1:0] crmd_wr;
    logic [`CSR_DATA_W-1:0] prmd_wr;
    logic [`CSR_DATA_W-1:0] ecfg_wr;
    logic [`CSR_DATA_W-1:0] estat_wr;
    logic [`CSR_DATA_W-1:0] eentry_wr;
    logic [`CSR_DATA_W-1:0] llbctl_wr;
    logic [`CSR_DATA_W-1:0] rdata;

    // new bit from wvalue where the mask is set, old bit elsewhere
    function automatic logic [`CSR_DATA_W-1:0] merge(input logic [`CSR_DATA_W-1:0] old_val);
        return (csr_acc.wmask & csr_acc.wvalue) | (~csr_acc.wmask & old_val);
    endfunction

    assign num = csr_num_e'(csr_acc.num);
    assign wen = csr_acc.we;

    // architectural views, reserved fields read zero
    // DA is fixed at 1 since paging is not modeled
    assign crmd_rd   = {28'b0, 1'b1, crmd_ie, crmd_plv};
    assign prmd_rd   = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg_rd   = {19'b0, ecfg_lie};
    assign estat_rd  = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign llbctl_rd = {29'b0, llbctl_klo, 2'b0};
    assign eentry    = {eentry_va, 6'b0};

    assign crmd_wr   = merge(crmd_rd);
    assign prmd_wr   = merge(prmd_rd);
    assign ecfg_wr   = merge(ecfg_rd);
    assign estat_wr  = merge(estat_rd);
    assign eentry_wr = merge(eentry);
    assign llbctl_wr = merge(llbctl_rd);

    assign exc_addr = wb_exc.valid &&
                      (wb_exc.ecode == `CSR_ECODE_ADE || wb_exc.ecode == `CSR_ECODE_ALE);
    assign ticlr_clr = wen && num == csr_ticlr && csr_acc.wmask[0] && csr_acc.wvalue[0];

    // mode state: exception, then ertn, then software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (wb_exc.valid) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wen && num == csr_crmd) begin
            crmd_plv <= crmd_wr[1:0];
            crmd_ie  <= crmd_wr[2];
        end else if (wen && num == csr_prmd) begin
            prmd_pplv <= prmd_wr[1:0];
            prmd_pie  <= prmd_wr[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            estat_is <= '0;
        end else begin
            if (wen && num == csr_ecfg) begin
                ecfg_lie <= ecfg_wr[12:0] & lie_mask;
            end
            // only the two software lines are writable
            if (wen && num == csr_estat) begin
                estat_is.sw <= estat_wr[1:0];
            end
            estat_is.hw   <= hw_int;
            estat_is.rsvd <= 1'b0;
            // fire beats a clear in the same cycle
            if (timer_fire) begin
                estat_is.timer <= 1'b1;
            end else if (ticlr_clr) begin
                estat_is.timer <= 1'b0;
            end
            estat_is.ipi <= 1'b0;
        end
    end

    // exception record
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
        end else begin
            if (wb_exc.valid) begin
                estat_ecode    <= wb_exc.ecode;
                estat_esubcode <= wb_exc.esubcode;
                era            <= wb_exc.pc;
            end else if (wen && num == csr_era) begin
                era <= merge(era);
            end
            if (exc_addr) begin
                badv <= (wb_exc.ecode == `CSR_ECODE_ADE) ? wb_exc.pc : wb_exc.vaddr;
            end else if (wen && num == csr_badv) begin
                badv <= merge(badv);
            end
        end
    end

    // plain software-owned registers
    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va  <= '0;
            llbctl_klo <= 1'b0;
            tid        <= core_id;
            tcfg_q     <= '0;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wen) begin
            case (num)
                csr_eentry: eentry_va <= eentry_wr[31:6];
                csr_llbctl: llbctl_klo <= llbctl_wr[2];
                csr_tid:    tid <= merge(tid);
                csr_tcfg:   tcfg_q <= tcfg_next;
                csr_save0, csr_save1, csr_save2, csr_save3:
                    save_q[csr_acc.num[1:0]] <= merge(save_q[csr_acc.num[1:0]]);
                default: ;
            endcase
        end
    end

    // timer sees the written config in the write cycle so it loads at that edge
    assign tcfg_wr   = wen && num == csr_tcfg;
    assign tcfg_next = tcfg_t'(merge(tcfg_q));
    assign tcfg      = tcfg_wr ? tcfg_next : tcfg_q;
    assign tcfg_load = tcfg_wr && tcfg_next.en;

    always_comb begin
        case (num)
            csr_crmd:   rdata = crmd_rd;
            csr_prmd:   rdata = prmd_rd;
            csr_ecfg:   rdata = ecfg_rd;
            csr_estat:  rdata = estat_rd;
            csr_era:    rdata = era;
            csr_badv:   rdata = badv;
            csr_eentry: rdata = eentry;
            csr_save0, csr_save1, csr_save2, csr_save3:
                rdata = save_q[csr_acc.num[1:0]];
            csr_tid:    rdata = tid;
            csr_tcfg:   rdata = tcfg_q;
            csr_tval:   rdata = tval;
            csr_llbctl: rdata = llbctl_rd;
            // TICLR is write-only
            default:    rdata = '0;
        endcase
    end

    assign csr_rvalue = csr_acc.re ? rdata : '0;

    // pipeline never retires an exception and an ertn together
    exc_ertn_excl: assert property (@(posedge clk) disable iff (reset)
        !(wb_exc.valid && ertn_flush))
        else $error("wb_exc.valid and ertn_flush both high");

    lie_bit10_zero: assert property (@(posedge clk) disable iff (reset)
        ecfg_lie.rsvd == 1'b0)
        else $error("ECFG.LIE bit 10 set");

endmodule

// ==== source/csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_timer import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  tcfg_t                  tcfg,
    input  logic                   tcfg_load,
    output logic [`CSR_DATA_W-1:0] tval,
    output logic                   timer_fire
);

    logic [`CSR_DATA_W-1:0] cnt;
    logic [`CSR_DATA_W-1:0] reload;
    logic                   idle;

    // initval counts in units of four cycles
    assign reload = {tcfg.initval, 2'b00};
    assign idle   = cnt == `CSR_TIMER_IDLE;

    // one cycle wide, the counter leaves zero at the next edge
    assign timer_fire = tcfg.en && cnt == '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= `CSR_TIMER_IDLE;
        end else if (tcfg_load && tcfg.en) begin
            cnt <= reload;
        end else if (tcfg.en && !idle) begin
            if (cnt == '0) begin
                // periodic restarts, one-shot parks at idle
                cnt <= tcfg.periodic ? reload : `CSR_TIMER_IDLE;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign tval = cnt;

    // an idle counter only restarts through a load
    idle_no_fire: assert property (@(posedge clk) disable iff (reset)
        idle && !tcfg_load |=> !timer_fire)
        else $error("timer fired out of idle without a load");

endmodule

// ==== source/csr_int_arbiter.sv ====
`timescale 1ns/1ps

module csr_int_arbiter import csr_pkg::*; (
    input  int_lines_t estat_is,
    input  int_lines_t ecfg_lie,
    input  logic       crmd_ie,
    output logic       int_req,
    output logic [3:0] int_index
);

    logic [12:0] pending;

    // a line counts only when both pending and locally enabled
    assign pending = estat_is & ecfg_lie;

    // global enable from CRMD.IE gates the request
    assign int_req = crmd_ie && |pending;

    // fixed priority, highest line number wins
    // scanning upward lets a later hit overwrite an earlier one
    always_comb begin
        int_index = 4'd0;
        for (int i = 0; i < 13; i++) begin
            if (pending[i]) begin
                int_index = 4'(i);
            end
        end
    end

endmodule

// ==== source/csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_unit import csr_pkg::*; #(
    parameter logic [`CSR_DATA_W-1:0] core_id = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_access_t            csr_acc,
    input  wb_exc_t                wb_exc,
    input  logic                   ertn_flush,
    input  logic [7:0]             hw_int,
    output logic [`CSR_DATA_W-1:0] csr_rvalue,
    output logic                   int_req,
    output logic [3:0]             int_index,
    output logic [`CSR_DATA_W-1:0] flush_pc,
    output logic                   flush_valid
);

    tcfg_t                  tcfg;
    logic                   tcfg_load;
    logic [`CSR_DATA_W-1:0] tval;
    logic                   timer_fire;
    int_lines_t             estat_is;
    int_lines_t             ecfg_lie;
    logic                   crmd_ie;
    logic [`CSR_DATA_W-1:0] eentry;
    logic [`CSR_DATA_W-1:0] era;

    csr_regfile #(
        .core_id(core_id)
    ) u_regfile (
        .clk       (clk),
        .reset     (reset),
        .csr_acc   (csr_acc),
        .wb_exc    (wb_exc),
        .ertn_flush(ertn_flush),
        .hw_int    (hw_int),
        .timer_fire(timer_fire),
        .tval      (tval),
        .csr_rvalue(csr_rvalue),
        .tcfg      (tcfg),
        .tcfg_load (tcfg_load),
        .estat_is  (estat_is),
        .ecfg_lie  (ecfg_lie),
        .crmd_ie   (crmd_ie),
        .eentry    (eentry),
        .era       (era)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .tcfg      (tcfg),
        .tcfg_load (tcfg_load),
        .tval      (tval),
        .timer_fire(timer_fire)
    );

    csr_int_arbiter u_int_arbiter (
        .estat_is (estat_is),
        .ecfg_lie (ecfg_lie),
        .crmd_ie  (crmd_ie),
        .int_req  (int_req),
        .int_index(int_index)
    );

    // redirect target uses the pre-edge EENTRY / ERA
    assign flush_valid = wb_exc.valid || ertn_flush;
    assign flush_pc    = wb_exc.valid ? eentry : era;

endmodule

// ==== dv/csr_clk_gen.sv ====
`timescale 1ns/1ps

module csr_clk_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_unit_tb import csr_pkg::*; ;

    localparam logic [31:0] tb_core_id = 32'h0000_0005;

    logic        clk;
    logic        reset;
    csr_access_t csr_acc;
    wb_exc_t     wb_exc;
    logic        ertn_flush;
    logic [7:0]  hw_int;
    logic [31:0] csr_rvalue;
    logic        int_req;
    logic [3:0]  int_index;
    logic [31:0] flush_pc;
    logic        flush_valid;

    // expected contents: save0-3, era, eentry, ecfg
    logic [31:0] model [7];
    int unsigned seed_init;

    csr_clk_gen clk_gen (
        .clk  (clk),
        .reset(reset)
    );

    csr_unit #(
        .core_id(tb_core_id)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .csr_acc    (csr_acc),
        .wb_exc     (wb_exc),
        .ertn_flush (ertn_flush),
        .hw_int     (hw_int),
        .csr_rvalue (csr_rvalue),
        .int_req    (int_req),
        .int_index  (int_index),
        .flush_pc   (flush_pc),
        .flush_valid(flush_valid)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    // every task starts and ends 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        csr_acc = '0;
        csr_acc.we = 1'b1;
        csr_acc.num = num;
        csr_acc.wmask = mask;
        csr_acc.wvalue = value;
        next_cycle();
        csr_acc = '0;
    endtask

    task automatic read_csr(input logic [13:0] num, output logic [31:0] data);
        csr_acc = '0;
        csr_acc.re = 1'b1;
        csr_acc.num = num;
        #1;
        data = csr_rvalue;
        next_cycle();
        csr_acc = '0;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 10) report_timeout("reset release");
        end
        next_cycle();
    endtask

    task automatic wait_estat_bit(input int bit_idx, input logic level, input string what,
                                  input int max_cycles);
        logic [31:0] rd;
        int cycles;
        cycles = 0;
        read_csr(csr_estat, rd);
        while (rd[bit_idx] !== level) begin
            cycles++;
            if (cycles > max_cycles) report_timeout(what);
            read_csr(csr_estat, rd);
        end
    endtask

    task automatic wait_int_req(input logic level, input string what, input int max_cycles);
        int cycles;
        cycles = 0;
        while (int_req !== level) begin
            cycles++;
            if (cycles > max_cycles) report_timeout(what);
            next_cycle();
        end
    endtask

    function automatic logic [13:0] reg_num(input int idx);
        case (idx)
            0: return csr_save0;
            1: return csr_save1;
            2: return csr_save2;
            3: return csr_save3;
            4: return csr_era;
            5: return csr_eentry;
            default: return csr_ecfg;
        endcase
    endfunction

    // bits that exist in each register, the rest read zero
    function automatic logic [31:0] field_mask(input int idx);
        case (idx)
            5: return 32'hffff_ffc0;
            6: return 32'h0000_1bff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    task automatic reset_and_masked_writes();
        logic [31:0] rd;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] expected;
        int idx;
        int n;
        read_csr(csr_tid, rd);
        check_value("reset tid", tb_core_id, rd);
        read_csr(csr_crmd, rd);
        check_value("reset crmd.ie", 32'h0, rd[2]);
        read_csr(csr_tval, rd);
        check_value("reset tval", `CSR_TIMER_IDLE, rd);
        check_value("reset int_req", 32'h0, int_req);
        check_value("reset flush_valid", 32'h0, flush_valid);
        for (n = 0; n < 40; n++) begin
            idx = $urandom % 7;
            mask = $urandom;
            value = $urandom;
            write_csr(reg_num(idx), mask, value);
            expected = ((mask & value) | (~mask & model[idx])) & field_mask(idx);
            model[idx] = expected;
            read_csr(reg_num(idx), rd);
            check_value($sformatf("masked write reg %0d", idx), expected, rd);
        end
        // gap in the CSR map
        write_csr(14'h043, 32'hffff_ffff, 32'hffff_ffff);
        read_csr(14'h043, rd);
        check_value("unimplemented read", 32'h0, rd);
    endtask

    task automatic exception_entry();
        logic [31:0] rd;
        write_csr(csr_crmd, 32'h7, 32'h7);
        read_csr(csr_crmd, rd);
        check_value("crmd plv3 ie1", 32'h7, rd[2:0]);
        write_csr(csr_eentry, 32'hffff_ffff, 32'h1c00_8040);
        model[5] = 32'h1c00_8040;

        wb_exc = '0;
        wb_exc.valid = 1'b1;
        wb_exc.ecode = `CSR_ECODE_ALE;
        wb_exc.esubcode = 9'h005;
        wb_exc.pc = 32'h1c00_1234;
        wb_exc.vaddr = 32'h0000_5677;
        #1;
        check_value("ale flush_valid", 32'h1, flush_valid);
        check_value("ale flush_pc", model[5], flush_pc);
        next_cycle();
        wb_exc = '0;
        model[4] = 32'h1c00_1234;

        read_csr(csr_crmd, rd);
        check_value("ale crmd", 32'h0, rd[2:0]);
        read_csr(csr_prmd, rd);
        check_value("ale prmd", 32'h7, rd[2:0]);
        read_csr(csr_era, rd);
        check_value("ale era", model[4], rd);
        read_csr(csr_badv, rd);
        check_value("ale badv", 32'h0000_5677, rd);
        read_csr(csr_estat, rd);
        check_value("ale estat codes", {9'h005, `CSR_ECODE_ALE}, rd[30:16]);

        // fetch address error records the pc instead
        wb_exc.valid = 1'b1;
        wb_exc.ecode = `CSR_ECODE_ADE;
        wb_exc.pc = 32'h1c00_2000;
        wb_exc.vaddr = 32'hdead_0000;
        #1;
        check_value("adef flush_pc", model[5], flush_pc);
        next_cycle();
        wb_exc = '0;
        model[4] = 32'h1c00_2000;
        read_csr(csr_badv, rd);
        check_value("adef badv", 32'h1c00_2000, rd);
    endtask

    task automatic exception_return();
        logic [31:0] rd;
        // pplv 2, pie 1
        write_csr(csr_prmd, 32'h7, 32'h6);
        read_csr(csr_prmd, rd);
        check_value("prmd before ertn", 32'h6, rd[2:0]);
        ertn_flush = 1'b1;
        #1;
        check_value("ertn flush_valid", 32'h1, flush_valid);
        check_value("ertn flush_pc", model[4], flush_pc);
        next_cycle();
        ertn_flush = 1'b0;
        read_csr(csr_crmd, rd);
        check_value("ertn crmd", 32'h6, rd[2:0]);
    endtask

    task automatic timer_modes();
        logic [31:0] rd;
        // one-shot, initval 3
        write_csr(csr_tcfg, 32'hffff_ffff, {30'd3, 1'b0, 1'b1});
        read_csr(csr_tval, rd);
        check_value("timer load", 32'd12, rd);
        read_csr(csr_tval, rd);
        check_value("timer count", 32'd11, rd);
        wait_estat_bit(11, 1'b1, "one-shot timer interrupt", 40);
        read_csr(csr_tval, rd);
        check_value("one-shot idle", `CSR_TIMER_IDLE, rd);
        write_csr(csr_ticlr, 32'h1, 32'h1);
        read_csr(csr_estat, rd);
        check_value("one-shot ticlr", 32'h0, rd[11]);

        // periodic, initval 2
        write_csr(csr_tcfg, 32'hffff_ffff, {30'd2, 1'b1, 1'b1});
        wait_estat_bit(11, 1'b1, "periodic timer interrupt", 40);
        write_csr(csr_ticlr, 32'h1, 32'h1);
        read_csr(csr_estat, rd);
        check_value("periodic ticlr", 32'h0, rd[11]);
        wait_estat_bit(11, 1'b1, "periodic timer interrupt again", 40);

        write_csr(csr_tcfg, 32'hffff_ffff, 32'h0);
        write_csr(csr_ticlr, 32'h1, 32'h1);
    endtask

    task automatic interrupt_request();
        // hw line 3 is IS bit 5
        hw_int = 8'h08;
        write_csr(csr_ecfg, 32'hffff_ffff, 32'h20);
        model[6] = 32'h20;
        write_csr(csr_crmd, 32'h4, 32'h4);
        wait_int_req(1'b1, "int_req from hw line 3", 10);
        check_value("int index hw3", 32'd5, int_index);

        write_csr(csr_crmd, 32'h4, 32'h0);
        wait_int_req(1'b0, "int_req drop on ie clear", 10);

        // sw line 0 pending too, hw3 still wins
        write_csr(csr_ecfg, 32'hffff_ffff, 32'h21);
        model[6] = 32'h21;
        write_csr(csr_estat, 32'h1, 32'h1);
        write_csr(csr_crmd, 32'h4, 32'h4);
        wait_int_req(1'b1, "int_req with sw and hw lines", 10);
        check_value("int index priority", 32'd5, int_index);

        hw_int = 8'h00;
        next_cycle();
        check_value("int index sw0", 32'd0, int_index);
        check_value("int_req sw0", 32'h1, int_req);
        write_csr(csr_estat, 32'h1, 32'h0);
    endtask

    initial begin
        csr_acc = '0;
        wb_exc = '0;
        ertn_flush = 1'b0;
        hw_int = 8'h00;
        for (int i = 0; i < 7; i++) begin
            model[i] = 32'h0;
        end
        seed_init = $urandom(32'hefe0ab51);

        wait_reset_release();
        reset_and_masked_writes();
        exception_entry();
        exception_return();
        timer_modes();
        interrupt_request();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== csr_unit.f ====
+incdir+include
source/csr_pkg.sv
source/csr_regfile.sv
source/csr_timer.sv
source/csr_int_arbiter.sv
source/csr_unit.sv
dv/csr_clk_gen.sv
dv/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  # RTL
  - include_dirs:
      - include
    files:
      - source/csr_pkg.sv
      - source/csr_regfile.sv
      - source/csr_timer.sv
      - source/csr_int_arbiter.sv
      - source/csr_unit.sv

  # testbench
  - target: test
    include_dirs:
      - include
    files:
      - dv/csr_clk_gen.sv
      - dv/csr_unit_tb.sv
